// File: include/exu_cfg.svh
`ifndef EXU_CFG_SVH
`define EXU_CFG_SVH

// datapath width of the core
`define EXU_XLEN  32

// architectural integer registers, x0 included
`define EXU_NREGS 32

// bits needed to address one register
`define EXU_RIDX  5

`endif

// File: rtl/exu_pkg.sv
`include "exu_cfg.svh"

package exu_pkg;

    // major opcodes handled by the execute path
    typedef enum logic [6:0] {
        OP_REG = 7'b0110011,
        OP_IMM = 7'b0010011
    } opcode_e;

    // encoding follows {funct7[5], funct3}
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b1000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_SRA  = 4'b1101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111
    } alu_op_e;

    typedef struct packed {
        alu_op_e               op;
        logic [`EXU_RIDX-1:0]  rs1;
        logic [`EXU_RIDX-1:0]  rs2;
        logic [`EXU_RIDX-1:0]  rd;
        logic                  use_imm;  // operand b from imm
        logic [`EXU_XLEN-1:0]  imm;      // sign-extended I-type
        logic                  illegal;
    } decoded_t;

    typedef struct packed {
        logic                  valid;
        logic                  illegal;
        logic [`EXU_RIDX-1:0]  rd;
        logic [`EXU_XLEN-1:0]  data;
    } wb_t;

endpackage

// File: rtl/adder.sv
`include "exu_cfg.svh"

module adder (
    input  logic                 sub,
    input  logic [`EXU_XLEN-1:0] a,
    input  logic [`EXU_XLEN-1:0] b,
    output logic [`EXU_XLEN-1:0] sum,
    output logic                 carry,
    output logic                 overflow
);

    localparam int MSB = `EXU_XLEN - 1;

    logic [`EXU_XLEN-1:0] b_eff;

    // two's complement subtract inverts b and carries in one
    assign b_eff = b ^ {`EXU_XLEN{sub}};

    assign {carry, sum} = {1'b0, a} + {1'b0, b_eff} + {{`EXU_XLEN{1'b0}}, sub};

    // same-sign inputs giving a result of the other sign
    assign overflow = (a[MSB] == b_eff[MSB]) && (sum[MSB] != a[MSB]);

endmodule

// File: rtl/alu.sv
`include "exu_cfg.svh"

module alu (
    input  exu_pkg::alu_op_e     op,
    input  logic [`EXU_XLEN-1:0] a,
    input  logic [`EXU_XLEN-1:0] b,
    output logic [`EXU_XLEN-1:0] res
);

    localparam int MSB = `EXU_XLEN - 1;
    localparam int SHW = $clog2(`EXU_XLEN);

    logic                 sub;
    logic [`EXU_XLEN-1:0] sum;
    logic                 carry;
    logic [SHW-1:0]       shamt;
    logic                 lt;

    assign shamt = b[SHW-1:0]; // low bits only

    // compares run through the subtractor
    assign sub = op inside {exu_pkg::ALU_SUB, exu_pkg::ALU_SLT, exu_pkg::ALU_SLTU};

    always_comb begin
        lt  = 1'b0;
        res = '0;
        case (op)
            exu_pkg::ALU_ADD: begin
                res = sum;
            end
            exu_pkg::ALU_SUB: begin
                res = sum;
            end
            exu_pkg::ALU_SLT: begin
                if (a[MSB] != b[MSB]) begin
                    lt = a[MSB];       // negative one is smaller
                end else begin
                    lt = sum[MSB];     // sign of the difference
                end
                res = {{(`EXU_XLEN-1){1'b0}}, lt};
            end
            exu_pkg::ALU_SLTU: begin
                lt  = ~carry;          // borrow out of a - b
                res = {{(`EXU_XLEN-1){1'b0}}, lt};
            end
            exu_pkg::ALU_SLL: begin
                res = a << shamt;
            end
            exu_pkg::ALU_SRL: begin
                res = a >> shamt;
            end
            exu_pkg::ALU_SRA: begin
                res = $unsigned($signed(a) >>> shamt); // sign fill
            end
            exu_pkg::ALU_XOR: begin
                res = a ^ b;
            end
            exu_pkg::ALU_OR: begin
                res = a | b;
            end
            exu_pkg::ALU_AND: begin
                res = a & b;
            end
            default: begin
                res = '0;
            end
        endcase
    end

    adder adder0 (
        .sub      (sub),
        .a        (a),
        .b        (b),
        .sum      (sum),
        .carry    (carry),
        .overflow ()
    );

endmodule

// File: rtl/inst_decode.sv
`include "exu_cfg.svh"

module inst_decode (
    input  logic [31:0]       inst,
    output exu_pkg::decoded_t dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        dec         = '0;
        dec.op      = exu_pkg::ALU_ADD;
        dec.rs1     = inst[19:15];
        dec.rs2     = inst[24:20];
        dec.rd      = inst[11:7];
        dec.imm     = {{(`EXU_XLEN-12){inst[31]}}, inst[31:20]};
        dec.use_imm = 1'b0;
        dec.illegal = 1'b0;

        case (opcode)
            exu_pkg::OP_REG: begin
                case (funct7)
                    7'b0000000: begin
                        case (funct3)
                            3'b000: dec.op = exu_pkg::ALU_ADD;
                            3'b001: dec.op = exu_pkg::ALU_SLL;
                            3'b010: dec.op = exu_pkg::ALU_SLT;
                            3'b011: dec.op = exu_pkg::ALU_SLTU;
                            3'b100: dec.op = exu_pkg::ALU_XOR;
                            3'b101: dec.op = exu_pkg::ALU_SRL;
                            3'b110: dec.op = exu_pkg::ALU_OR;
                            3'b111: dec.op = exu_pkg::ALU_AND;
                        endcase
                    end
                    7'b0100000: begin
                        case (funct3)
                            3'b000:  dec.op = exu_pkg::ALU_SUB;
                            3'b101:  dec.op = exu_pkg::ALU_SRA;
                            default: dec.illegal = 1'b1;
                        endcase
                    end
                    default: begin
                        dec.illegal = 1'b1;
                    end
                endcase
            end
            exu_pkg::OP_IMM: begin
                dec.use_imm = 1'b1;
                dec.rs2     = '0; // field holds imm bits
                case (funct3)
                    3'b000: dec.op = exu_pkg::ALU_ADD;
                    3'b010: dec.op = exu_pkg::ALU_SLT;
                    3'b011: dec.op = exu_pkg::ALU_SLTU;
                    3'b100: dec.op = exu_pkg::ALU_XOR;
                    3'b110: dec.op = exu_pkg::ALU_OR;
                    3'b111: dec.op = exu_pkg::ALU_AND;
                    3'b001: begin
                        dec.op = exu_pkg::ALU_SLL;
                        if (funct7 != 7'b0000000) begin
                            dec.illegal = 1'b1;
                        end
                    end
                    3'b101: begin
                        if (funct7 == 7'b0000000) begin
                            dec.op = exu_pkg::ALU_SRL;
                        end else if (funct7 == 7'b0100000) begin
                            dec.op = exu_pkg::ALU_SRA;
                        end else begin
                            dec.illegal = 1'b1;
                        end
                    end
                endcase
            end
            default: begin
                dec.illegal = 1'b1; // not an ALU instruction
            end
        endcase
    end

endmodule

// File: rtl/regfile.sv
`include "exu_cfg.svh"

module regfile (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`EXU_RIDX-1:0] raddr1,
    input  logic [`EXU_RIDX-1:0] raddr2,
    output logic [`EXU_XLEN-1:0] rdata1,
    output logic [`EXU_XLEN-1:0] rdata2,
    input  logic                 we,
    input  logic [`EXU_RIDX-1:0] waddr,
    input  logic [`EXU_XLEN-1:0] wdata
);

    // x0 has no storage
    logic [`EXU_XLEN-1:0] regs [1:`EXU_NREGS-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `EXU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: rtl/exec_unit.sv
`include "exu_cfg.svh"

module exec_unit (
    input  logic          clk,
    input  logic          rst,
    input  logic [31:0]   inst,
    input  logic          inst_valid,
    output exu_pkg::wb_t  wb
);

    exu_pkg::decoded_t    dec;      // issuing instruction
    exu_pkg::decoded_t    iss_dec;  // instruction in the alu stage
    logic                 iss_valid;
    logic [`EXU_XLEN-1:0] iss_a;
    logic [`EXU_XLEN-1:0] iss_b;

    logic [`EXU_XLEN-1:0] rf_rdata1;
    logic [`EXU_XLEN-1:0] rf_rdata2;
    logic                 rf_we;
    logic [`EXU_RIDX-1:0] rf_waddr;
    logic [`EXU_XLEN-1:0] rf_wdata;

    logic                 fwd_hit_a;
    logic                 fwd_hit_b;
    logic [`EXU_XLEN-1:0] fwd_a;
    logic [`EXU_XLEN-1:0] fwd_b;
    logic [`EXU_XLEN-1:0] alu_res;

    inst_decode dec0 (
        .inst (inst),
        .dec  (dec)
    );

    regfile rf0 (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    // retire write except for x0 or illegal
    assign rf_we    = iss_valid && !iss_dec.illegal && (iss_dec.rd != '0);
    assign rf_waddr = iss_dec.rd;
    assign rf_wdata = alu_res;

    // bypass alu result to the issuing instruction
    assign fwd_hit_a = rf_we && (iss_dec.rd == dec.rs1);
    assign fwd_hit_b = rf_we && (iss_dec.rd == dec.rs2);
    assign fwd_a     = fwd_hit_a ? alu_res : rf_rdata1;
    assign fwd_b     = dec.use_imm ? dec.imm : (fwd_hit_b ? alu_res : rf_rdata2);

    always_ff @(posedge clk) begin
        if (rst) begin
            iss_valid <= 1'b0;
        end else begin
            iss_valid <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        iss_dec <= dec;
        iss_a   <= fwd_a;
        iss_b   <= fwd_b;
    end

    alu alu0 (
        .op  (iss_dec.op),
        .a   (iss_a),
        .b   (iss_b),
        .res (alu_res)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid   <= iss_valid;
            wb.illegal <= iss_dec.illegal;
            wb.rd      <= iss_dec.rd;
            wb.data    <= iss_dec.illegal ? '0 : alu_res; // zero on illegal
        end
    end

endmodule

// File: test/exec_unit_asserts.sv
`include "exu_cfg.svh"

module exec_unit_asserts (
    input logic                 clk,
    input logic                 rst,
    input logic                 inst_valid,
    input exu_pkg::wb_t         wb,
    input logic                 rf_we,
    input logic [`EXU_RIDX-1:0] rf_waddr
);
    timeunit 1ns;
    timeprecision 1ps;

    // issue edge, alu edge, then retire
    wb_latency: assert property (@(posedge clk) disable iff (rst)
        wb.valid == $past(inst_valid, 2))
        else $error("writeback valid not two edges after issue");

    wb_reset: assert property (@(posedge clk)
        rst |=> !wb.valid)
        else $error("writeback valid high during reset");

    illegal_zero: assert property (@(posedge clk) disable iff (rst)
        (wb.valid && wb.illegal) |-> (wb.data == '0))
        else $error("illegal writeback carries nonzero data");

    no_x0_write: assert property (@(posedge clk) disable iff (rst)
        rf_we |-> (rf_waddr != '0))
        else $error("register file write enabled for x0");

endmodule

bind exec_unit exec_unit_asserts asserts0 (
    .clk        (clk),
    .rst        (rst),
    .inst_valid (inst_valid),
    .wb         (wb),
    .rf_we      (rf_we),
    .rf_waddr   (rf_waddr)
);

// File: test/exec_unit_tb.sv
`include "exu_cfg.svh"

module exec_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic         clk = 1'b0;
    logic         rst;
    logic [31:0]  inst;
    logic         inst_valid;
    exu_pkg::wb_t wb;

    logic [`EXU_XLEN-1:0] mregs [0:`EXU_NREGS-1]; // reference register copy
    exu_pkg::wb_t         expq [$];               // expected retirements in order
    int                   cycle = 0;              // rising edges so far
    int                   dueq [$];               // cycle each retirement is due

    exec_unit dut0 (
        .clk        (clk),
        .rst        (rst),
        .inst       (inst),
        .inst_valid (inst_valid),
        .wb         (wb)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_wb(input exu_pkg::wb_t got, input exu_pkg::wb_t exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH at %0t: wb rd %0d ill %0b data %h, %s",
                $time, got.rd, got.illegal, got.data,
                $sformatf("expected rd %0d ill %0b data %h", exp.rd, exp.illegal, exp.data)));
        end
    endtask

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    // RV32I semantics for OP and OP-IMM and illegal for anything else
    function automatic exu_pkg::wb_t model_exec(input logic [31:0] ins);
        logic [6:0]   opc;
        logic [2:0]   f3;
        logic [6:0]   f7;
        logic         is_reg;
        logic         ill;
        logic [31:0]  a;
        logic [31:0]  b;
        logic [4:0]   sh;
        logic [31:0]  r;
        exu_pkg::wb_t e;
        opc    = ins[6:0];
        f3     = ins[14:12];
        f7     = ins[31:25];
        is_reg = (opc == 7'b0110011);
        a      = mregs[ins[19:15]];
        b      = is_reg ? mregs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
        sh     = b[4:0];
        ill    = 1'b0;
        if (is_reg) begin
            ill = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
        end else if (opc == 7'b0010011) begin
            if (f3 == 3'b001) ill = (f7 != 7'h00);
            if (f3 == 3'b101) ill = (f7 != 7'h00 && f7 != 7'h20);
        end else begin
            ill = 1'b1;
        end
        case (f3)
            3'b000: r = (is_reg && f7[5]) ? a - b : a + b;
            3'b001: r = a << sh;
            3'b010: r = {31'b0, $signed(a) < $signed(b)};
            3'b011: r = {31'b0, a < b};
            3'b100: r = a ^ b;
            3'b101: begin
                if (f7[5]) r = $signed(a) >>> sh; // arithmetic
                else r = a >> sh;
            end
            3'b110: r = a | b;
            default: r = a & b;
        endcase
        e.valid   = 1'b1;
        e.illegal = ill;
        e.rd      = ins[11:7];
        e.data    = ill ? '0 : r;
        return e;
    endfunction

    task automatic issue(input logic [31:0] ins);
        exu_pkg::wb_t e;
        @(negedge clk);
        e = model_exec(ins);
        expq.push_back(e);
        dueq.push_back(cycle + 2);
        if (!e.illegal && e.rd != 0) mregs[e.rd] = e.data;
        inst       = ins;
        inst_valid = 1'b1;
    endtask

    task automatic idle_cycle;
        @(negedge clk);
        inst_valid = 1'b0;
        inst       = $urandom; // junk while idle
    endtask

    task automatic drain;
        int waited;
        idle_cycle();
        waited = 0;
        while (expq.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > 10) fail_run("writeback did not arrive");
        end
    endtask

    // builds v 11 bits at a time from back-to-back steps
    task automatic load_reg(input logic [4:0] rd, input logic [31:0] v);
        issue(i_type({1'b0, v[31:21]}, 5'd0, 3'b000, rd));
        issue(i_type(12'd11, rd, 3'b001, rd));
        issue(i_type({1'b0, v[20:10]}, rd, 3'b100, rd));
        issue(i_type(12'd10, rd, 3'b001, rd));
        issue(i_type({2'b0, v[9:0]}, rd, 3'b100, rd));
    endtask

    always @(negedge clk) begin
        if (!rst && wb.valid === 1'b1) begin
            if (expq.size() == 0) begin
                fail_run("writeback arrived with no instruction outstanding");
            end else begin
                if (dueq.pop_front() != cycle) begin
                    fail_run("writeback arrived in the wrong cycle");
                end
                check_wb(wb, expq.pop_front());
            end
        end
    end

    task automatic reset_and_x0;
        issue(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd8)); // registers cleared by reset
        issue(i_type(12'h123, 5'd0, 3'b000, 5'd5));
        issue(i_type(12'h800, 5'd0, 3'b000, 5'd6));
        issue(i_type(12'h055, 5'd0, 3'b000, 5'd0)); // write to x0
        issue(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd7)); // no forward from x0
        idle_cycle();
        issue(i_type(12'h000, 5'd0, 3'b110, 5'd9));
        drain();
    endtask

    task automatic alu_ops(input logic [11:0] imm);
        issue(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        issue(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
        issue(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd5));
        issue(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
        issue(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd7));
        issue(i_type(imm, 5'd1, 3'b000, 5'd8));
        issue(i_type(imm, 5'd1, 3'b100, 5'd9));
        issue(i_type(imm, 5'd1, 3'b110, 5'd10));
        issue(i_type(imm, 5'd1, 3'b111, 5'd11));
        drain();
    endtask

    task automatic arith_logic;
        load_reg(5'd1, 32'hffff_ffff);
        load_reg(5'd2, 32'h0000_0001);
        alu_ops(12'h001); // add wraps to zero
        issue(r_type(7'h20, 5'd2, 5'd0, 3'b000, 5'd4)); // 0 - 1
        for (int i = 0; i < 8; i++) begin
            load_reg(5'd1, $urandom);
            load_reg(5'd2, $urandom);
            alu_ops(12'($urandom));
        end
    endtask

    task automatic cmp_pair(input logic [31:0] a, input logic [31:0] b);
        load_reg(5'd1, a);
        load_reg(5'd2, b);
        issue(r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd3));
        issue(r_type(7'h00, 5'd2, 5'd1, 3'b011, 5'd4));
        issue(i_type(b[11:0], 5'd1, 3'b010, 5'd5));
        issue(i_type(b[11:0], 5'd1, 3'b011, 5'd6));
        issue(i_type(12'h800, 5'd1, 3'b010, 5'd7));
        issue(i_type(12'hfff, 5'd1, 3'b011, 5'd8));
        drain();
    endtask

    task automatic compares;
        cmp_pair(32'h8000_0000, 32'h0000_0001);
        cmp_pair(32'h0000_0001, 32'h8000_0000);
        cmp_pair(32'h8000_0000, 32'h8000_0000);
        cmp_pair(32'h7fff_ffff, 32'h8000_0000);
        cmp_pair(32'h0000_0005, 32'h0000_0007);
        cmp_pair(32'h0000_0007, 32'h0000_0005);
        cmp_pair(32'hffff_fffd, 32'hffff_fffe);
        cmp_pair(32'hffff_fffe, 32'hffff_fffd);
        for (int i = 0; i < 4; i++) begin
            cmp_pair($urandom, $urandom);
        end
    endtask

    task automatic shift_set(input logic [31:0] v, input logic [4:0] amt);
        logic [31:0] s;
        s      = $urandom;
        s[4:0] = amt; // upper bits must be ignored
        load_reg(5'd1, v);
        load_reg(5'd2, s);
        issue(r_type(7'h00, 5'd2, 5'd1, 3'b001, 5'd3));
        issue(r_type(7'h00, 5'd2, 5'd1, 3'b101, 5'd4));
        issue(r_type(7'h20, 5'd2, 5'd1, 3'b101, 5'd5));
        issue(i_type({7'h00, amt}, 5'd1, 3'b001, 5'd6));
        issue(i_type({7'h00, amt}, 5'd1, 3'b101, 5'd7));
        issue(i_type({7'h20, amt}, 5'd1, 3'b101, 5'd8));
        drain();
    endtask

    task automatic shifts;
        logic [4:0] amts [4];
        amts = '{5'd0, 5'd31, 5'($urandom), 5'($urandom)};
        foreach (amts[i]) begin
            shift_set(32'h8000_0000 | $urandom, amts[i]);
            shift_set(32'h7fff_ffff & $urandom, amts[i]);
        end
    endtask

    task automatic run_chain(input bit gap);
        logic [4:0] prev;
        logic [4:0] rd;
        logic [4:0] other;
        load_reg(5'd10, $urandom);
        prev = 5'd10;
        for (int i = 0; i < 16; i++) begin
            rd    = 5'd10 + 5'($urandom % 6);
            other = 5'd1 + 5'($urandom % 15);
            case ($urandom % 4)
                0: issue(r_type(7'h00, prev, prev, 3'b000, rd));
                1: issue(r_type(7'h20, other, prev, 3'b000, rd));
                2: issue(r_type(7'h00, prev, other, 3'b100, rd)); // dependence on rs2
                default: issue(i_type(12'($urandom), prev, 3'b000, rd));
            endcase
            prev = rd;
            if (gap) idle_cycle();
        end
        drain();
    endtask

    task automatic forwarding;
        run_chain(1'b0);
        run_chain(1'b1);
    endtask

    task automatic issue_bad_opcode(input logic [6:0] opc, input logic [4:0] rd);
        logic [31:0] x;
        x       = $urandom;
        x[11:7] = rd;
        x[6:0]  = opc;
        issue(x);
    endtask

    task automatic illegal_insts;
        load_reg(5'd20, $urandom);
        issue_bad_opcode(7'b0000011, 5'd20); // load
        issue_bad_opcode(7'b1100011, 5'd20); // branch
        issue_bad_opcode(7'b0110111, 5'd20);
        issue(r_type(7'h01, 5'd2, 5'd1, 3'b000, 5'd20));
        issue(r_type(7'h20, 5'd2, 5'd1, 3'b100, 5'd20));
        issue(i_type({7'h20, 5'd3}, 5'd1, 3'b001, 5'd20));
        issue(i_type({7'h01, 5'd3}, 5'd1, 3'b101, 5'd20));
        issue(i_type(12'h000, 5'd20, 3'b000, 5'd21)); // old value read back to back
        idle_cycle();
        issue(i_type(12'h000, 5'd20, 3'b000, 5'd22));
        drain();
    endtask

    initial begin
        void'($urandom(32'he20168a0));
        rst        = 1'b1;
        inst       = '0;
        inst_valid = 1'b0;
        for (int i = 0; i < `EXU_NREGS; i++) begin
            mregs[i] = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        reset_and_x0();
        arith_logic();
        compares();
        shifts();
        forwarding();
        illegal_insts();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: exec_unit.f
+incdir+include
rtl/exu_pkg.sv
rtl/adder.sv
rtl/alu.sv
rtl/inst_decode.sv
rtl/regfile.sv
rtl/exec_unit.sv
test/exec_unit_asserts.sv
test/exec_unit_tb.sv
